/* include/cnn_consts.svh */
// ----------------------------------------
// cnn front end constants
// widths, kernel weights, clip limit and
// synchronizer depth
// ----------------------------------------
`ifndef CNN_CONSTS_SVH
`define CNN_CONSTS_SVH

// pixel and feature byte width
`define CNN_PIXEL_W 8

// signed accumulator, covers -510 .. 765
`define CNN_ACC_W 11

// bit counter for one spi byte
`define CNN_BITCNT_W 3

// sck / ssel_n synchronizer depth
`define CNN_SYNC_STAGES 3

// kernel weights: newest, middle, oldest pixel
`define CNN_W0 3
`define CNN_W1 (-1)
`define CNN_W2 (-1)

// upper clip limit after relu
`define CNN_FEAT_MAX 255

`endif

/* rtl/cnn_pkg.sv */
`default_nettype none
// ----------------------------------------
// cnn front end data types and state enums
// ----------------------------------------
`include "cnn_consts.svh"

package cnn_pkg;

  // unsigned pixel or feature byte
  typedef logic [`CNN_PIXEL_W-1:0] pixel_t;

  // signed convolution sum
  typedef logic signed [`CNN_ACC_W-1:0] acc_t;

  // how many pixels the conv window holds
  typedef enum logic [1:0] {
    FILL_EMPTY,
    FILL_ONE,
    FILL_FULL
  } fill_state_t;

  // position inside a pooling pair
  typedef enum logic {
    POOL_FIRST,
    POOL_SECOND
  } pool_phase_t;

endpackage

`default_nettype wire

/* rtl/spi_slave_if.sv */
`default_nettype none
// ----------------------------------------
// spi mode 0 slave front end
// syncs the pins, shifts bytes msb first,
// hands pixels on, returns pooled features
// ----------------------------------------
`include "cnn_consts.svh"

module spi_slave_if
  import cnn_pkg::*;
(
  input  logic   CLK,
  input  logic   rst_n,
  input  logic   sck,
  input  logic   ssel_n,
  input  logic   mosi,
  input  pixel_t pooled,
  output logic   miso,
  output pixel_t pixel,
  output logic   pixel_valid,
  output logic   frame_clear
);

  // pin synchronizers, oldest sample in the msb
  logic [`CNN_SYNC_STAGES-1:0] sck_sync;
  logic [`CNN_SYNC_STAGES-1:0] ssel_sync;
  // mosi one stage shorter so it lines up with the sck edge
  logic [`CNN_SYNC_STAGES-2:0] mosi_sync;

  logic                     sck_rise;
  logic                     sck_fall;
  logic                     mosi_bit;
  logic [`CNN_BITCNT_W-1:0] bitcnt;
  logic                     byte_done;
  pixel_t                   rx_byte;
  pixel_t                   tx_byte;

  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      sck_sync  <= '0;
      // ssel_n idles high, frame starts cleared
      ssel_sync <= '1;
      mosi_sync <= '0;
    end else begin
      sck_sync  <= {sck_sync[`CNN_SYNC_STAGES-2:0], sck};
      ssel_sync <= {ssel_sync[`CNN_SYNC_STAGES-2:0], ssel_n};
      mosi_sync <= {mosi_sync[`CNN_SYNC_STAGES-3:0], mosi};
    end
  end

  // edges seen on the two oldest sck samples
  assign sck_rise = (sck_sync[`CNN_SYNC_STAGES-1 -: 2] == 2'b01);
  assign sck_fall = (sck_sync[`CNN_SYNC_STAGES-1 -: 2] == 2'b10);
  assign mosi_bit = mosi_sync[`CNN_SYNC_STAGES-2];

  // frame is held cleared while ssel_n is inactive
  assign frame_clear = ssel_sync[`CNN_SYNC_STAGES-1];

  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      bitcnt      <= '0;
      byte_done   <= 1'b0;
      rx_byte     <= '0;
      tx_byte     <= '0;
      pixel_valid <= 1'b0;
    end else if (frame_clear) begin
      bitcnt      <= '0;
      byte_done   <= 1'b0;
      rx_byte     <= '0;
      tx_byte     <= '0;
      pixel_valid <= 1'b0;
    end else begin
      // single cycle pulse
      pixel_valid <= 1'b0;
      // sample mosi on sck rise
      if (sck_rise) begin
        bitcnt    <= bitcnt + 1'b1;
        rx_byte   <= {rx_byte[`CNN_PIXEL_W-2:0], mosi_bit};
        // bit 7 done, pixel complete next cycle
        byte_done   <= (bitcnt == '1);
        pixel_valid <= (bitcnt == '1);
      end
      // drive miso on sck fall
      if (sck_fall) begin
        if (byte_done) begin
          // first fall after a full byte, reply with the latest pooled value
          tx_byte <= pooled;
        end else begin
          tx_byte <= {tx_byte[`CNN_PIXEL_W-2:0], 1'b0};
        end
      end
    end
  end

  // rx_byte holds still until the next sck rise, so it doubles as the pixel
  assign pixel = rx_byte;

  // msb first, no tri-state with a single slave
  assign miso = tx_byte[`CNN_PIXEL_W-1];

endmodule

`default_nettype wire

/* rtl/conv_tap_stage.sv */
`default_nettype none
// ----------------------------------------
// three tap 1-d convolution
// fixed weights, relu and saturation to a byte
// ----------------------------------------
`include "cnn_consts.svh"

module conv_tap_stage
  import cnn_pkg::*;
(
  input  logic   CLK,
  input  logic   rst_n,
  input  logic   frame_clear,
  input  pixel_t pixel,
  input  logic   pixel_valid,
  output pixel_t feat,
  output logic   feat_valid
);

  // previous and oldest pixel of the window
  pixel_t      pix_d1;
  pixel_t      pix_d2;
  fill_state_t fill;
  acc_t        sum;
  pixel_t      clipped;

  // weighted sum, newest pixel on w0
  assign sum = acc_t'(`CNN_W0) * acc_t'(pixel)
             + acc_t'(`CNN_W1) * acc_t'(pix_d1)
             + acc_t'(`CNN_W2) * acc_t'(pix_d2);

  // relu then clip at the top of the byte range
  always_comb begin
    if (sum < 0) begin
      clipped = '0;
    end else if (sum > acc_t'(`CNN_FEAT_MAX)) begin
      clipped = pixel_t'(`CNN_FEAT_MAX);
    end else begin
      clipped = pixel_t'(sum);
    end
  end

  // fill tracking and output strobe
  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      fill       <= FILL_EMPTY;
      feat_valid <= 1'b0;
    end else if (frame_clear) begin
      fill       <= FILL_EMPTY;
      feat_valid <= 1'b0;
    end else begin
      // only fires once two older pixels are already held
      feat_valid <= pixel_valid && (fill == FILL_FULL);
      if (pixel_valid) begin
        case (fill)
          FILL_EMPTY: fill <= FILL_ONE;
          FILL_ONE:   fill <= FILL_FULL;
          default:    fill <= FILL_FULL;
        endcase
      end
    end
  end

  // window shift and result register
  always_ff @(posedge CLK) begin
    if (pixel_valid) begin
      pix_d2 <= pix_d1;
      pix_d1 <= pixel;
      feat   <= clipped;
    end
  end

endmodule

`default_nettype wire

/* rtl/max_pool_stage.sv */
`default_nettype none
// ----------------------------------------
// pairwise max pooling
// keeps the latest pooled feature
// ----------------------------------------

module max_pool_stage
  import cnn_pkg::*;
(
  input  logic   CLK,
  input  logic   rst_n,
  input  logic   frame_clear,
  input  pixel_t feat,
  input  logic   feat_valid,
  output pixel_t pooled
);

  pool_phase_t phase;
  // first feature of the open pair
  pixel_t      first_feat;

  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      phase  <= POOL_FIRST;
      pooled <= '0;
    end else if (frame_clear) begin
      phase  <= POOL_FIRST;
      pooled <= '0;
    end else if (feat_valid) begin
      if (phase == POOL_FIRST) begin
        phase <= POOL_SECOND;
      end else begin
        phase <= POOL_FIRST;
        // pair complete, keep the larger one
        pooled <= (feat > first_feat) ? feat : first_feat;
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (feat_valid && (phase == POOL_FIRST)) begin
      first_feat <= feat;
    end
  end

endmodule

`default_nettype wire

/* rtl/cnn_spi_top.sv */
`default_nettype none
// ----------------------------------------
// spi cnn front end top
// spi slave -> conv -> max pool -> back to miso
// ----------------------------------------

module cnn_spi_top
  import cnn_pkg::*;
(
  input  logic CLK,
  input  logic rst_n,
  input  logic sck,
  input  logic ssel_n,
  input  logic mosi,
  output logic miso
);

  // received pixel stream
  pixel_t pixel;
  logic   pixel_valid;
  // high while ssel_n is inactive
  logic   frame_clear;

  // conv results
  pixel_t feat;
  logic   feat_valid;

  // held pooled feature, returned on miso
  pixel_t pooled;

  spi_slave_if u_spi (
    .CLK         (CLK),
    .rst_n       (rst_n),
    .sck         (sck),
    .ssel_n      (ssel_n),
    .mosi        (mosi),
    .pooled      (pooled),
    .miso        (miso),
    .pixel       (pixel),
    .pixel_valid (pixel_valid),
    .frame_clear (frame_clear)
  );

  conv_tap_stage u_conv (
    .CLK         (CLK),
    .rst_n       (rst_n),
    .frame_clear (frame_clear),
    .pixel       (pixel),
    .pixel_valid (pixel_valid),
    .feat        (feat),
    .feat_valid  (feat_valid)
  );

  max_pool_stage u_pool (
    .CLK         (CLK),
    .rst_n       (rst_n),
    .frame_clear (frame_clear),
    .feat        (feat),
    .feat_valid  (feat_valid),
    .pooled      (pooled)
  );

endmodule

`default_nettype wire

/* tb/tb_clock.sv */
`default_nettype none
// ----------------------------------------
// testbench clock and reset
// 4 unit period, reset held for 3 cycles
// ----------------------------------------

module tb_clock (
  output logic CLK,
  output logic rst_n
);

  initial begin
    CLK = 1'b0;
    forever #2 CLK = ~CLK;
  end

  // release away from the rising edge
  initial begin
    rst_n = 1'b0;
    repeat (3) @(posedge CLK);
    @(negedge CLK);
    rst_n = 1'b1;
  end

endmodule

`default_nettype wire

/* tb/tb_cnn_spi.sv */
`default_nettype none
// ----------------------------------------
// testbench for the spi cnn front end
// spi master, reference model, directed tests
// ----------------------------------------

module tb_cnn_spi;

  // sck high and low time in CLK cycles
  localparam int HALF_BIT = 10;
  // bytes over all tests with the partial byte counted as one
  localparam int TOTAL_BYTES = 83;
  localparam int WATCHDOG_CYCLES = TOTAL_BYTES * 2 * HALF_BIT * 8 + 1000;

  logic CLK;
  logic rst_n;
  logic sck;
  logic ssel_n;
  logic mosi;
  logic miso;

  // pixels of the current frame and the bytes seen on miso
  int          frame_px [0:63];
  int          replies  [0:63];
  logic [31:0] rng_state;

  tb_clock u_clock (
    .CLK   (CLK),
    .rst_n (rst_n)
  );

  cnn_spi_top uut (
    .CLK    (CLK),
    .rst_n  (rst_n),
    .sck    (sck),
    .ssel_n (ssel_n),
    .mosi   (mosi),
    .miso   (miso)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // y_k = 3 p_k - p_(k-1) - p_(k-2) with relu and a clip at 255
  function automatic int conv_ref(input int k);
    int s;
    s = 3 * frame_px[k] - frame_px[k-1] - frame_px[k-2];
    if (s < 0) s = 0;
    else if (s > 255) s = 255;
    return s;
  endfunction

  // reply during byte k is the latest pooled value from pixels 0..k-1
  function automatic int expected_reply(input int k);
    int pairs;
    int a;
    int b;
    pairs = (k >= 2) ? (k - 2) / 2 : 0;
    if (pairs == 0) return 0;
    a = conv_ref(2 * pairs);
    b = conv_ref(2 * pairs + 1);
    return (a > b) ? a : b;
  endfunction

  task automatic check_byte(input string name, input int idx, input int got, input int exp);
    assert (got == exp) else begin
      $display("Mismatch at time %0t: miso byte %0d (%s) got 0x%02h expected 0x%02h",
               $time, idx, name, got, exp);
      $display("TEST FAILED");
      $fatal(1, "stopping at first error");
    end
  endtask

  // mode 0 msb first transfer that starts and ends on a falling CLK edge
  task automatic spi_xfer(input logic [7:0] tx, input int nbits, output logic [7:0] rx);
    int i;
    rx = '0;
    for (i = 7; i > 7 - nbits; i--) begin
      mosi = tx[i];
      repeat (HALF_BIT) @(negedge CLK);
      sck   = 1'b1;
      rx[i] = miso;
      repeat (HALF_BIT) @(negedge CLK);
      sck   = 1'b0;
    end
  endtask

  task automatic select_slave();
    ssel_n = 1'b0;
    repeat (HALF_BIT) @(negedge CLK);
  endtask

  // long enough for the synchronized ssel to clear the frame
  task automatic release_slave();
    repeat (HALF_BIT) @(negedge CLK);
    ssel_n = 1'b1;
    mosi   = 1'b0;
    repeat (2 * HALF_BIT) @(negedge CLK);
  endtask

  // sends frame_px[0..n-1] as one frame and checks every reply against the model
  task automatic run_frame(input int n);
    logic [7:0] rx;
    int k;
    select_slave();
    for (k = 0; k < n; k++) begin
      spi_xfer(frame_px[k][7:0], 8, rx);
      replies[k] = int'(rx);
      check_byte("frame reply", k, replies[k], expected_reply(k));
    end
    release_slave();
  endtask

  task automatic steady_pixels();
    int k;
    check_byte("after reset", 0, int'(miso), 0);
    for (k = 0; k < 6; k++) frame_px[k] = 100;
    run_frame(6);
    // flat input gives 3*100 - 100 - 100
    check_byte("steady reply", 4, replies[4], 100);
  endtask

  task automatic rising_ramp();
    int k;
    for (k = 0; k < 8; k++) frame_px[k] = 10 * (k + 1);
    run_frame(8);
  endtask

  task automatic clip_limits();
    int pattern [0:7];
    int k;
    pattern = '{0, 0, 200, 200, 0, 0, 0, 0};
    for (k = 0; k < 8; k++) frame_px[k] = pattern[k];
    run_frame(8);
    // first pair saturates and the second pair has only negative sums
    check_byte("clip high reply", 4, replies[4], 255);
    check_byte("clip low reply", 6, replies[6], 0);
  endtask

  task automatic pool_order();
    int pattern [0:7];
    int k;
    pattern = '{10, 10, 90, 10, 10, 60, 0, 0};
    for (k = 0; k < 8; k++) frame_px[k] = pattern[k];
    run_frame(8);
    // larger value first in pair 0 and second in pair 1
    check_byte("pool first larger", 4, replies[4], 250);
    check_byte("pool second larger", 6, replies[6], 160);
  endtask

  task automatic frame_abort();
    logic [7:0] rx;
    int k;
    for (k = 0; k < 6; k++) frame_px[k] = 40 + 15 * k;
    run_frame(6);
    // abort a frame three bits into its first byte
    select_slave();
    spi_xfer(8'hA5, 3, rx);
    check_byte("aborted byte", 0, int'(rx), 0);
    release_slave();
    for (k = 0; k < 6; k++) frame_px[k] = 120 - 10 * k;
    run_frame(6);
  endtask

  task automatic random_frame();
    int k;
    for (k = 0; k < 40; k++) begin
      rng_state   = xorshift32(rng_state);
      frame_px[k] = int'(rng_state[7:0]);
    end
    run_frame(40);
  endtask

  // watchdog sized from the total byte count
  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge CLK);
    $display("timeout: tests did not finish within %0d clock cycles", WATCHDOG_CYCLES);
    $display("TEST FAILED");
    $fatal(1, "watchdog expired");
  end

  initial begin
    sck       = 1'b0;
    ssel_n    = 1'b1;
    mosi      = 1'b0;
    rng_state = 32'd48782;
    wait (rst_n === 1'b1);
    @(negedge CLK);
    steady_pixels();
    rising_ramp();
    clip_limits();
    pool_order();
    frame_abort();
    random_frame();
    $display("TEST PASSED");
    $finish;
  end

endmodule

`default_nettype wire

/* cnn_spi.f */
+incdir+include
rtl/cnn_pkg.sv
rtl/spi_slave_if.sv
rtl/conv_tap_stage.sv
rtl/max_pool_stage.sv
rtl/cnn_spi_top.sv
tb/tb_clock.sv
tb/tb_cnn_spi.sv

/* Makefile */
# Verilator build for the SPI CNN front end

TOP        ?= tb_cnn_spi
RTL_TOP    ?= cnn_spi_top
FILELIST   ?= cnn_spi.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
FLAGS      ?=
LINT_FLAGS ?= -Wall
VERILATOR  ?= verilator

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing $(LINT_FLAGS) $(FLAGS) \
		-f $(FILELIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) --binary --timing $(FLAGS) -f $(FILELIST) \
		--top-module $(TOP) -Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "TEST PASSED" $(LOG) && echo "sim: pass" || \
		(echo "sim: fail, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
